//--- vga_timing_pkg.sv
// 640x480 timing constants, derived blanking bounds, counter and colour types
package vga_timing_pkg;

  // horizontal timing in pixel clocks, sync first then back porch
  localparam int SYNC_PULSE_HORZ  = 96;
  localparam int BACK_PORCH_HORZ  = 48;
  localparam int ACTIVE_COLS      = 640;
  localparam int FRONT_PORCH_HORZ = 16;

  // vertical timing in lines, same ordering
  localparam int SYNC_PULSE_VERT  = 2;
  localparam int BACK_PORCH_VERT  = 33;
  localparam int ACTIVE_ROWS      = 480;
  localparam int FRONT_PORCH_VERT = 10;

  // full line and frame, 800 clocks by 525 lines
  localparam int TOTAL_COLS = SYNC_PULSE_HORZ + BACK_PORCH_HORZ + ACTIVE_COLS + FRONT_PORCH_HORZ;
  localparam int TOTAL_ROWS = SYNC_PULSE_VERT + BACK_PORCH_VERT + ACTIVE_ROWS + FRONT_PORCH_VERT;

  // first and last visible column and row (144..783, 35..514)
  localparam int H_ACTIVE_START = SYNC_PULSE_HORZ + BACK_PORCH_HORZ;
  localparam int H_ACTIVE_LAST  = TOTAL_COLS - FRONT_PORCH_HORZ - 1;
  localparam int V_ACTIVE_START = SYNC_PULSE_VERT + BACK_PORCH_VERT;
  localparam int V_ACTIVE_LAST  = TOTAL_ROWS - FRONT_PORCH_VERT - 1;

  // 10 bits cover both 800 columns and 525 rows
  localparam int COUNT_W = 10;
  typedef logic [COUNT_W-1:0] count_t;

  // 4 bits per channel, 12-bit RGB overall
  localparam int COLOR_W = 4;
  typedef logic [COLOR_W-1:0] color_t;

  // eight equal colour bars across the visible line
  localparam int NUM_BARS = 8;
  localparam int BAR_W    = 3;
  localparam int BAR_COLS = ACTIVE_COLS / NUM_BARS;

endpackage

//--- vga_sync_gen.sv
// free-running 800x525 column/row counters with registered horizontal and vertical sync
`timescale 1ns/100ps

module vga_sync_gen
  (
  input        i_Clk,
  input        i_rst_n,
  output logic o_hsync,
  output logic o_vsync
  );

  import vga_timing_pkg::*;

  // current position in the frame
  count_t r_col;
  count_t r_row;

  // position for the next clock
  count_t w_col_next;
  count_t w_row_next;

  // end of line and end of frame flags
  logic w_line_end;
  logic w_frame_end;

  assign w_line_end  = (r_col == count_t'(TOTAL_COLS - 1));
  assign w_frame_end = (r_row == count_t'(TOTAL_ROWS - 1));

  // next position, column wraps every 800 clocks and bumps the row
  always_comb
  begin
    w_col_next = r_col + 1'b1;
    w_row_next = r_row;
    if (w_line_end)
    begin
      w_col_next = '0;
      // row wraps after the last front porch line
      if (w_frame_end)
      begin
        w_row_next = '0;
      end
      else
      begin
        w_row_next = r_row + 1'b1;
      end
    end
  end

  // counters
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_col <= '0;
      r_row <= '0;
    end
    else
    begin
      r_col <= w_col_next;
      r_row <= w_row_next;
    end
  end

  // syncs decoded from the next position so the registered
  // outputs line up with r_col and r_row in the same clock
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
    end
    else
    begin
      // hsync over columns 0..95
      o_hsync <= (w_col_next < count_t'(SYNC_PULSE_HORZ));
      // vsync over rows 0..1, full lines
      o_vsync <= (w_row_next < count_t'(SYNC_PULSE_VERT));
    end
  end

endmodule

//--- sync_to_count.sv
// column/row recovery from hsync and vsync, with syncs re-timed to the counts
`timescale 1ns/100ps

module sync_to_count
  (
  input                          i_Clk,
  input                          i_rst_n,
  input                          i_hsync,
  input                          i_vsync,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output vga_timing_pkg::count_t o_col,
  output vga_timing_pkg::count_t o_row
  );

  import vga_timing_pkg::*;

  // one clock copies of the incoming syncs
  logic r_hsync;
  logic r_vsync;

  // recovered position
  count_t r_col;
  count_t r_row;

  // vsync rising edge marks column 0 row 0
  logic w_frame_start;

  // wrap points
  logic w_line_end;
  logic w_frame_end;

  assign w_frame_start = i_vsync & ~r_vsync;
  assign w_line_end    = (r_col == count_t'(TOTAL_COLS - 1));
  assign w_frame_end   = (r_row == count_t'(TOTAL_ROWS - 1));

  // sync delay, keeps the syncs in step with the counts below
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_hsync <= 1'b0;
      r_vsync <= 1'b0;
    end
    else
    begin
      r_hsync <= i_hsync;
      r_vsync <= i_vsync;
    end
  end

  // counts restart on the frame edge, otherwise free-run with wrap
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_col <= '0;
      r_row <= '0;
    end
    else if (w_frame_start)
    begin
      r_col <= '0;
      r_row <= '0;
    end
    else if (w_line_end)
    begin
      r_col <= '0;
      // row follows the column wrap
      if (w_frame_end)
      begin
        r_row <= '0;
      end
      else
      begin
        r_row <= r_row + 1'b1;
      end
    end
    else
    begin
      r_col <= r_col + 1'b1;
    end
  end

  assign o_hsync = r_hsync;
  assign o_vsync = r_vsync;
  assign o_col   = r_col;
  assign o_row   = r_row;

endmodule

//--- sync_to_blanking.sv
// horizontal and vertical blanking decode from recovered column and row counts
`timescale 1ns/100ps

module sync_to_blanking
  (
  input  vga_timing_pkg::count_t i_col,
  input  vga_timing_pkg::count_t i_row,
  output logic                   o_hblank,
  output logic                   o_vblank
  );

  import vga_timing_pkg::*;

  // sides of each blanking window
  logic w_h_lead;
  logic w_h_trail;
  logic w_v_lead;
  logic w_v_trail;

  // sync pulse plus back porch sits at the start of the line
  assign w_h_lead  = (i_col < count_t'(H_ACTIVE_START));
  // front porch closes the line
  assign w_h_trail = (i_col > count_t'(H_ACTIVE_LAST));

  // same layout vertically, in lines
  assign w_v_lead  = (i_row < count_t'(V_ACTIVE_START));
  assign w_v_trail = (i_row > count_t'(V_ACTIVE_LAST));

  // blank outside 144..783 and 35..514
  // purely combinational, no added latency
  always_comb
  begin
    o_hblank = w_h_lead | w_h_trail;
    o_vblank = w_v_lead | w_v_trail;
  end

endmodule

//--- vga_test_pattern.sv
// eight-bar colour pattern with blanking forced to black and matched sync/blank delay
`timescale 1ns/100ps

module vga_test_pattern
  (
  input                          i_Clk,
  input                          i_rst_n,
  input  vga_timing_pkg::count_t i_col,
  input                          i_hblank,
  input                          i_vblank,
  input                          i_hsync,
  input                          i_vsync,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic                   o_hblank,
  output logic                   o_vblank,
  output vga_timing_pkg::color_t o_red,
  output vga_timing_pkg::color_t o_grn,
  output vga_timing_pkg::color_t o_blu
  );

  import vga_timing_pkg::*;

  // column relative to the first visible pixel
  count_t w_vis_col;

  // bar index 0..7
  logic [BAR_W-1:0] w_bar;

  // either blank forces black
  logic w_blank;

  assign w_vis_col = i_col - count_t'(H_ACTIVE_START);
  // wraps during the leading blank, harmless since the pixel is black there
  assign w_bar     = BAR_W'(w_vis_col / count_t'(BAR_COLS));
  assign w_blank   = i_hblank | i_vblank;

  // one register stage for video and the timing that goes with it
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_hsync  <= 1'b0;
      o_vsync  <= 1'b0;
      o_hblank <= 1'b1;
      o_vblank <= 1'b1;
      o_red    <= '0;
      o_grn    <= '0;
      o_blu    <= '0;
    end
    else
    begin
      o_hsync  <= i_hsync;
      o_vsync  <= i_vsync;
      o_hblank <= i_hblank;
      o_vblank <= i_vblank;
      if (w_blank)
      begin
        o_red <= '0;
        o_grn <= '0;
        o_blu <= '0;
      end
      else
      begin
        // bit 2 red, bit 1 green, bit 0 blue, each at full scale
        o_red <= {COLOR_W{w_bar[2]}};
        o_grn <= {COLOR_W{w_bar[1]}};
        o_blu <= {COLOR_W{w_bar[0]}};
      end
    end
  end

endmodule

//--- vga_blank_top.sv
// top level chaining sync generator, count recovery, blanking decode and bar pattern
`timescale 1ns/100ps

module vga_blank_top
  (
  input                          i_Clk,
  input                          i_rst_n,
  output                         o_hsync,
  output                         o_vsync,
  output                         o_hblank,
  output                         o_vblank,
  output vga_timing_pkg::color_t o_red,
  output vga_timing_pkg::color_t o_grn,
  output vga_timing_pkg::color_t o_blu
  );

  import vga_timing_pkg::*;

  // raw syncs from the generator
  logic w_gen_hsync;
  logic w_gen_vsync;

  // syncs and position after recovery, all aligned
  logic   w_hsync;
  logic   w_vsync;
  count_t w_col;
  count_t w_row;

  // blanking for the recovered position
  logic w_hblank;
  logic w_vblank;

  vga_sync_gen i_vga_sync_gen (
    .i_Clk   (i_Clk),
    .i_rst_n (i_rst_n),
    .o_hsync (w_gen_hsync),
    .o_vsync (w_gen_vsync)
  );

  // count recovery sees only the syncs, as a display would
  sync_to_count i_sync_to_count (
    .i_Clk   (i_Clk),
    .i_rst_n (i_rst_n),
    .i_hsync (w_gen_hsync),
    .i_vsync (w_gen_vsync),
    .o_hsync (w_hsync),
    .o_vsync (w_vsync),
    .o_col   (w_col),
    .o_row   (w_row)
  );

  sync_to_blanking i_sync_to_blanking (
    .i_col    (w_col),
    .i_row    (w_row),
    .o_hblank (w_hblank),
    .o_vblank (w_vblank)
  );

  // final stage, all outputs leave together one clock later
  vga_test_pattern i_vga_test_pattern (
    .i_Clk    (i_Clk),
    .i_rst_n  (i_rst_n),
    .i_col    (w_col),
    .i_hblank (w_hblank),
    .i_vblank (w_vblank),
    .i_hsync  (w_hsync),
    .i_vsync  (w_vsync),
    .o_hsync  (o_hsync),
    .o_vsync  (o_vsync),
    .o_hblank (o_hblank),
    .o_vblank (o_vblank),
    .o_red    (o_red),
    .o_grn    (o_grn),
    .o_blu    (o_blu)
  );

endmodule

//--- tb_vga_blank.sv
// testbench for vga_blank_top with reset, edge table, sync period and random pixel checks
`timescale 1ns/100ps

module tb_vga_blank;

  import vga_timing_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int FRAME_CLKS  = TOTAL_COLS * TOTAL_ROWS;
  // partial frame, table frame, random frame, plus one spare
  localparam int WATCHDOG_NS = 4 * FRAME_CLKS * CLK_PERIOD;
  localparam int NUM_RANDOM  = 64;
  localparam int MAX_ENTRIES = 32;
  localparam int FULL_SCALE  = (1 << COLOR_W) - 1;

  logic   i_Clk;
  logic   i_rst_n;
  logic   o_hsync;
  logic   o_vsync;
  logic   o_hblank;
  logic   o_vblank;
  color_t o_red;
  color_t o_grn;
  color_t o_blu;

  // model position, restarts at every vsync rising edge
  int   m_col;
  int   m_row;
  int   vrise_count;
  int   clk_count;
  int   last_hrise;
  int   last_vrise;
  int   line_len;
  int   frame_len;
  logic prev_hsync;
  logic prev_vsync;

  // check bookkeeping
  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int tests_run;

  // edge point table
  int   n_entries;
  int   t_row [MAX_ENTRIES];
  int   t_col [MAX_ENTRIES];
  logic t_hs  [MAX_ENTRIES];
  logic t_vs  [MAX_ENTRIES];
  logic t_hb  [MAX_ENTRIES];
  logic t_vb  [MAX_ENTRIES];
  int   t_red [MAX_ENTRIES];
  int   t_grn [MAX_ENTRIES];
  int   t_blu [MAX_ENTRIES];

  int unsigned lcg_state;

  vga_blank_top i_vga_blank_top (
    .i_Clk    (i_Clk),
    .i_rst_n  (i_rst_n),
    .o_hsync  (o_hsync),
    .o_vsync  (o_vsync),
    .o_hblank (o_hblank),
    .o_vblank (o_vblank),
    .o_red    (o_red),
    .o_grn    (o_grn),
    .o_blu    (o_blu)
  );

  // 10 MHz nominal here, only edges matter
  initial
  begin
    i_Clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: vertical sync never arrived or the tests did not finish in %0d ns",
             WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic int unsigned lcg_next(input int unsigned state);
    lcg_next = state * 32'd1103515245 + 32'd12345;
  endfunction

  // expected outputs straight from the timing rules
  task automatic expected_pixel(input int row, input int col, output logic hs, output logic vs,
                                output logic hb, output logic vb, output int r, output int g,
                                output int b);
    int bar;
    begin
      hs = (col < SYNC_PULSE_HORZ);
      vs = (row < SYNC_PULSE_VERT);
      hb = (col < SYNC_PULSE_HORZ + BACK_PORCH_HORZ) ||
           (col >= TOTAL_COLS - FRONT_PORCH_HORZ);
      vb = (row < SYNC_PULSE_VERT + BACK_PORCH_VERT) ||
           (row >= TOTAL_ROWS - FRONT_PORCH_VERT);
      r = 0;
      g = 0;
      b = 0;
      if (!hb && !vb)
      begin
        bar = (col - SYNC_PULSE_HORZ - BACK_PORCH_HORZ) / BAR_COLS;
        // bit 2 red, bit 1 green, bit 0 blue
        r = bar[2] ? FULL_SCALE : 0;
        g = bar[1] ? FULL_SCALE : 0;
        b = bar[0] ? FULL_SCALE : 0;
      end
    end
  endtask

  task automatic add_entry(input int row, input int col, input logic hs, input logic vs,
                           input logic hb, input logic vb, input int r, input int g, input int b);
    begin
      t_row[n_entries] = row;
      t_col[n_entries] = col;
      t_hs[n_entries]  = hs;
      t_vs[n_entries]  = vs;
      t_hb[n_entries]  = hb;
      t_vb[n_entries]  = vb;
      t_red[n_entries] = r;
      t_grn[n_entries] = g;
      t_blu[n_entries] = b;
      n_entries++;
    end
  endtask

  // sorted by position in the frame so one pass covers them all
  task automatic load_table;
    begin
      n_entries = 0;
      // vertical edges at column 400, bar 3
      add_entry(1, 400, 0, 1, 0, 1, 0, 0, 0);
      add_entry(2, 400, 0, 0, 0, 1, 0, 0, 0);
      add_entry(34, 400, 0, 0, 0, 1, 0, 0, 0);
      add_entry(35, 400, 0, 0, 0, 0, 0, 15, 15);
      // horizontal edges on a visible line
      add_entry(100, 0, 1, 0, 1, 0, 0, 0, 0);
      add_entry(100, 95, 1, 0, 1, 0, 0, 0, 0);
      add_entry(100, 96, 0, 0, 1, 0, 0, 0, 0);
      add_entry(100, 143, 0, 0, 1, 0, 0, 0, 0);
      add_entry(100, 144, 0, 0, 0, 0, 0, 0, 0);
      add_entry(100, 223, 0, 0, 0, 0, 0, 0, 0);
      add_entry(100, 224, 0, 0, 0, 0, 0, 0, 15);
      add_entry(100, 783, 0, 0, 0, 0, 15, 15, 15);
      add_entry(100, 784, 0, 0, 1, 0, 0, 0, 0);
      // middle of each bar
      add_entry(240, 184, 0, 0, 0, 0, 0, 0, 0);
      add_entry(240, 264, 0, 0, 0, 0, 0, 0, 15);
      add_entry(240, 344, 0, 0, 0, 0, 0, 15, 0);
      add_entry(240, 424, 0, 0, 0, 0, 0, 15, 15);
      add_entry(240, 504, 0, 0, 0, 0, 15, 0, 0);
      add_entry(240, 584, 0, 0, 0, 0, 15, 0, 15);
      add_entry(240, 664, 0, 0, 0, 0, 15, 15, 0);
      add_entry(240, 744, 0, 0, 0, 0, 15, 15, 15);
      // bottom edge of the visible area
      add_entry(514, 400, 0, 0, 0, 0, 0, 15, 15);
      add_entry(515, 400, 0, 0, 0, 1, 0, 0, 0);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    begin
      checks++;
      test_checks++;
      if (actual !== expected)
      begin
        errors++;
        test_errors++;
        $display("MISMATCH at %0t ns: %s at row %0d col %0d, got %0h expected %0h",
                 $time, name, m_row, m_col, actual, expected);
      end
    end
  endtask

  task automatic compare_outputs(input logic hs, input logic vs, input logic hb, input logic vb,
                                 input int r, input int g, input int b);
    begin
      check_value("o_hsync", o_hsync, hs);
      check_value("o_vsync", o_vsync, vs);
      check_value("o_hblank", o_hblank, hb);
      check_value("o_vblank", o_vblank, vb);
      check_value("o_red", o_red, r);
      check_value("o_grn", o_grn, g);
      check_value("o_blu", o_blu, b);
    end
  endtask

  task automatic start_test;
    begin
      test_checks = 0;
      test_errors = 0;
    end
  endtask

  task automatic finish_test(input string name);
    begin
      tests_run++;
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    end
  endtask

  // one pixel clock, sampled on the falling edge where outputs are settled
  task automatic advance_pixel;
    begin
      @(negedge i_Clk);
      clk_count++;
      if (o_hsync && !prev_hsync)
      begin
        if (last_hrise >= 0)
          line_len = clk_count - last_hrise;
        last_hrise = clk_count;
      end
      if (o_vsync && !prev_vsync)
      begin
        if (last_vrise >= 0)
          frame_len = clk_count - last_vrise;
        last_vrise = clk_count;
        vrise_count++;
        m_col = 0;
        m_row = 0;
      end
      else if (m_col == TOTAL_COLS - 1)
      begin
        m_col = 0;
        m_row = (m_row == TOTAL_ROWS - 1) ? 0 : m_row + 1;
      end
      else
      begin
        m_col++;
      end
      prev_hsync = o_hsync;
      prev_vsync = o_vsync;
    end
  endtask

  task automatic wait_position(input int row, input int col);
    begin
      while (!(m_row == row && m_col == col))
        advance_pixel();
    end
  endtask

  initial
  begin
    int   i;
    int   seg;
    int   pos;
    logic e_hs;
    logic e_vs;
    logic e_hb;
    logic e_vb;
    int   e_r;
    int   e_g;
    int   e_b;

    i_rst_n     = 1'b0;
    m_col       = 0;
    m_row       = 0;
    vrise_count = 0;
    clk_count   = 0;
    last_hrise  = -1;
    last_vrise  = -1;
    line_len    = 0;
    frame_len   = 0;
    prev_hsync  = 1'b0;
    prev_vsync  = 1'b0;
    checks      = 0;
    errors      = 0;
    tests_run   = 0;
    load_table();

    // outputs idle while reset is held
    start_test();
    repeat (2) @(posedge i_Clk);
    @(negedge i_Clk);
    compare_outputs(1'b0, 1'b0, 1'b1, 1'b1, 0, 0, 0);
    finish_test("reset state");
    repeat (2) @(posedge i_Clk);
    i_rst_n <= 1'b1;

    // skip the partial first frame
    while (vrise_count < 2)
      advance_pixel();

    start_test();
    for (i = 0; i < n_entries; i++)
    begin
      wait_position(t_row[i], t_col[i]);
      compare_outputs(t_hs[i], t_vs[i], t_hb[i], t_vb[i], t_red[i], t_grn[i], t_blu[i]);
    end
    finish_test("edge table");

    // line and frame length between sync rising edges
    start_test();
    while (vrise_count < 3)
      advance_pixel();
    check_value("line length", line_len, TOTAL_COLS);
    check_value("frame length", frame_len, FRAME_CLKS);
    finish_test("sync periods");

    // one random position per slice of the frame keeps them ascending
    start_test();
    lcg_state = 32'd95388;
    seg = FRAME_CLKS / NUM_RANDOM;
    for (i = 0; i < NUM_RANDOM; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      pos = i * seg + int'((lcg_state >> 8) % seg);
      wait_position(pos / TOTAL_COLS, pos % TOTAL_COLS);
      expected_pixel(pos / TOTAL_COLS, pos % TOTAL_COLS, e_hs, e_vs, e_hb, e_vb, e_r, e_g, e_b);
      compare_outputs(e_hs, e_vs, e_hb, e_vb, e_r, e_g, e_b);
    end
    finish_test("random samples");

    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vga_blank.f
vga_timing_pkg.sv
vga_sync_gen.sv
sync_to_count.sv
sync_to_blanking.sv
vga_test_pattern.sv
vga_blank_top.sv
tb_vga_blank.sv

//--- Bender.yml
package:
  name: vga_blank

sources:
  - vga_timing_pkg.sv
  - vga_sync_gen.sv
  - sync_to_count.sv
  - sync_to_blanking.sv
  - vga_test_pattern.sv
  - vga_blank_top.sv
  - target: test
    files:
      - tb_vga_blank.sv
